// File: rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] pc_start = 32'h0000_0000;
  localparam logic [xlen-1:0] pc_step  = 32'd4;

  // encodings of the one-bit selects in ctrl_t
  localparam logic sel_pc_step     = 1'b0;
  localparam logic sel_pc_target   = 1'b1;
  localparam logic sel_addr_pc     = 1'b0;
  localparam logic sel_addr_result = 1'b1;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    cls_alu_reg, cls_alu_imm, cls_ld, cls_st, cls_br, cls_jmp, cls_illegal
  } instr_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_fmt_e;

  typedef enum logic [2:0] {
    s_fetch, s_decode, s_execute, s_memory, s_writeback
  } ctrl_state_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;

  typedef struct packed {
    instr_class_e cls;
    alu_op_e      alu_op;
    imm_fmt_e     imm_fmt;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    logic         bne;          // branch when operands differ
  } decode_t;

  typedef struct packed {
    logic    instr_load;        // capture instruction word
    logic    operand_load;      // capture rs1, rs2 / immediate
    logic    result_load;       // capture alu result
    logic    reg_write;
    wb_sel_e wb_sel;
    logic    pc_load;
    logic    pc_sel;            // step or target
    logic    mem_addr_sel;      // pc or result
    logic    mem_write;
  } ctrl_t;

endpackage

`default_nettype wire

// File: rv32i_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_alu import rv32i_pkg::*; (
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_e op,
  output word_t        result,
  output logic         zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];             // rv32 shifts use 5 bits only

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
      alu_xor:  result = a ^ b;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

  // sub followed by zero gives beq / bne
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import rv32i_pkg::*; (
  input  wire           clk,
  input  wire reg_idx_t rd_addr0,
  input  wire reg_idx_t rd_addr1,
  output word_t         rd_data0,
  output word_t         rd_data1,
  input  wire           wr_en,
  input  wire reg_idx_t wr_addr,
  input  wire word_t    wr_data
);

  word_t regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (wr_en && wr_addr != '0) begin   // x0 is hardwired
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

  // a write aimed at x0 must not become visible on the next read
  x0_stays_zero: assert property (@(posedge clk)
    (wr_en && wr_addr == '0) ##1 (rd_addr0 == '0) |-> (rd_data0 == '0))
    else $error("x0 read back nonzero after write");

endmodule

`default_nettype wire

// File: immediate_extender.sv
`timescale 1ns/1ns
`default_nettype none

module immediate_extender import rv32i_pkg::*; (
  input  wire word_t    instr,
  input  wire imm_fmt_e fmt,
  output word_t         imm
);

  logic sign;

  assign sign = instr[31];           // sign bit sits at 31 in every format

  always_comb begin
    case (fmt)
      imm_s: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      imm_b: begin
        imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      imm_j: begin
        imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin                 // i format
        imm = {{20{sign}}, instr[31:20]};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: instruction_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder import rv32i_pkg::*; (
  input  wire word_t instr,
  output decode_t    dec
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_fn = alt ? alu_sub : alu_add;
      3'b001:  alu_fn = alu_sll;
      3'b010:  alu_fn = alu_slt;
      3'b011:  alu_fn = alu_sltu;
      3'b100:  alu_fn = alu_xor;
      3'b101:  alu_fn = alt ? alu_sra : alu_srl;
      3'b110:  alu_fn = alu_or;
      default: alu_fn = alu_and;
    endcase
  endfunction

  always_comb begin
    dec.cls     = cls_illegal;
    dec.alu_op  = alu_add;
    dec.imm_fmt = imm_i;
    dec.rd      = instr[11:7];
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.bne     = funct3[0];
    case (opcode)
      opc_op: begin
        // funct7 bit 5 only legal for sub and sra
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.cls    = cls_alu_reg;
          dec.alu_op = alu_fn(funct3, funct7[5]);
        end
      end
      opc_op_imm: begin
        if (funct3 == 3'b001) begin
          if (funct7 == 7'b0000000) dec.cls = cls_alu_imm;
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0000000 || funct7 == 7'b0100000) dec.cls = cls_alu_imm;
        end else begin
          dec.cls = cls_alu_imm;
        end
        dec.alu_op = alu_fn(funct3, funct3 == 3'b101 && funct7[5]); // addi has no sub form
      end
      opc_load: begin
        if (funct3 == 3'b010) dec.cls = cls_ld;         // lw only
      end
      opc_store: begin
        if (funct3 == 3'b010) dec.cls = cls_st;         // sw only
        dec.imm_fmt = imm_s;
      end
      opc_branch: begin
        if (funct3[2:1] == 2'b00) dec.cls = cls_br;     // beq, bne
        dec.alu_op  = alu_sub;
        dec.imm_fmt = imm_b;
      end
      opc_jal: begin
        dec.cls     = cls_jmp;
        dec.imm_fmt = imm_j;
      end
      default: ;                     // stays illegal, skipped as nop
    endcase
  end

endmodule

`default_nettype wire

// File: core_controller.sv
`timescale 1ns/1ns
`default_nettype none

module core_controller import rv32i_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          ena,
  input  wire decode_t dec,
  input  wire          alu_zero,
  output ctrl_t        ctrl
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        take_target;

  // beq taken on zero, bne taken on nonzero; jal always jumps
  assign take_target = (dec.cls == cls_jmp) ||
                       (dec.cls == cls_br && (alu_zero ^ dec.bne));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_fetch;
    end else if (ena) begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_fetch:  state_next = s_decode;
      s_decode: state_next = s_execute;
      s_execute: begin
        case (dec.cls)
          cls_alu_reg, cls_alu_imm: state_next = s_writeback;
          cls_ld, cls_st:           state_next = s_memory;
          default:                  state_next = s_fetch;   // br, jmp, illegal end here
        endcase
      end
      s_memory: begin
        state_next = (dec.cls == cls_ld) ? s_writeback : s_fetch;
      end
      s_writeback: state_next = s_fetch;
      default:     state_next = s_fetch;
    endcase
  end

  always_comb begin
    ctrl              = '0;
    ctrl.wb_sel       = wb_alu;
    ctrl.pc_sel       = sel_pc_step;
    ctrl.mem_addr_sel = sel_addr_pc;  // memory keeps rereading the pc word
    case (state)
      s_decode: begin
        ctrl.instr_load   = 1'b1;
        ctrl.operand_load = 1'b1;
      end
      s_execute: begin
        ctrl.result_load = 1'b1;
        ctrl.pc_load     = 1'b1;     // every class advances the pc here
        if (take_target) begin
          ctrl.pc_sel = sel_pc_target;
        end
        if (dec.cls == cls_jmp) begin
          ctrl.reg_write = 1'b1;
          ctrl.wb_sel    = wb_link;
        end
      end
      s_memory: begin
        ctrl.mem_addr_sel = sel_addr_result;
        ctrl.mem_write    = (dec.cls == cls_st);
      end
      s_writeback: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = (dec.cls == cls_ld) ? wb_mem : wb_alu;
      end
      default: ;
    endcase

    // freeze: strobes drop, selects hold so mem_addr stays put
    ctrl.instr_load   = ctrl.instr_load & ena;
    ctrl.operand_load = ctrl.operand_load & ena;
    ctrl.result_load  = ctrl.result_load & ena;
    ctrl.reg_write    = ctrl.reg_write & ena;
    ctrl.pc_load      = ctrl.pc_load & ena;
    ctrl.mem_write    = ctrl.mem_write & ena;
  end

  // stores only from the memory step of an sw
  store_in_memory_only: assert property (@(posedge clk) disable iff (rst)
    ctrl.mem_write |-> (state == s_memory && dec.cls == cls_st))
    else $error("mem_write outside store memory step");

  // memory and writeback last exactly one enabled cycle
  no_linger: assert property (@(posedge clk) disable iff (rst)
    (ena && (state == s_memory || state == s_writeback)) |=> (state != $past(state)))
    else $error("state held in memory or writeback");

endmodule

`default_nettype wire

// File: rv32i_multicycle_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_multicycle_core import rv32i_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        ena,
  output word_t      mem_addr,
  input  wire word_t mem_rd_data,
  output word_t      mem_wr_data,
  output logic       mem_wr_en,
  output word_t      pc
);

  ctrl_t   ctrl;
  decode_t dec;
  decode_t pre_dec;
  word_t   pc_q;
  word_t   ir_q;
  word_t   opa_q;
  word_t   opb_q;
  word_t   store_q;
  word_t   result_q;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   fetch_imm;
  word_t   instr_imm;
  word_t   alu_y;
  word_t   pc_plus4;
  word_t   target;
  word_t   wb_data;
  logic    alu_zero;
  logic    use_imm;

  // early decode of the word on mem_rd_data, used only while operands are captured
  instruction_decoder pre_decoder_inst (.instr(mem_rd_data), .dec(pre_dec));
  immediate_extender pre_imm_inst (
    .instr(mem_rd_data), .fmt(pre_dec.imm_fmt), .imm(fetch_imm)
  );

  instruction_decoder instruction_decoder_inst (.instr(ir_q), .dec(dec));
  immediate_extender immediate_extender_inst (
    .instr(ir_q), .fmt(dec.imm_fmt), .imm(instr_imm)
  );

  register_file register_file_inst (
    .clk      (clk),
    .rd_addr0 (pre_dec.rs1),
    .rd_addr1 (pre_dec.rs2),
    .rd_data0 (rs1_data),
    .rd_data1 (rs2_data),
    .wr_en    (ctrl.reg_write),
    .wr_addr  (dec.rd),
    .wr_data  (wb_data)
  );

  rv32i_alu rv32i_alu_inst (
    .a(opa_q), .b(opb_q), .op(dec.alu_op), .result(alu_y), .zero(alu_zero)
  );

  core_controller core_controller_inst (
    .clk(clk), .rst(rst), .ena(ena), .dec(dec), .alu_zero(alu_zero), .ctrl(ctrl)
  );

  assign use_imm  = pre_dec.cls inside {cls_alu_imm, cls_ld, cls_st};
  assign pc_plus4 = pc_q + pc_step;
  assign target   = pc_q + instr_imm;  // branch / jal target, alu stays free

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= pc_start;
    end else if (ctrl.pc_load) begin
      pc_q <= (ctrl.pc_sel == sel_pc_target) ? target : pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.instr_load) begin
      ir_q <= mem_rd_data;
    end
    if (ctrl.operand_load) begin
      opa_q   <= rs1_data;
      opb_q   <= use_imm ? fetch_imm : rs2_data;
      store_q <= rs2_data;             // sw data
    end
    if (ctrl.result_load) begin
      result_q <= alu_y;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = mem_rd_data;  // lw word arrives in writeback
      wb_link: wb_data = pc_plus4;
      default: wb_data = result_q;
    endcase
  end

  assign mem_addr    = (ctrl.mem_addr_sel == sel_addr_result) ? result_q : pc_q;
  assign mem_wr_data = store_q;
  assign mem_wr_en   = ctrl.mem_write;
  assign pc          = pc_q;

endmodule

`default_nettype wire

// File: tb_rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core import rv32i_pkg::*; ();

  localparam int mem_words   = 256;
  localparam int prog_len    = 200;            // random words, register setup included
  localparam int freeze_len  = 30;
  localparam int timeout_cyc = 20000;

  logic  clk = 1'b0;
  logic  rst;
  logic  ena;
  word_t mem_addr;
  word_t mem_rd_data;
  word_t mem_wr_data;
  logic  mem_wr_en;
  word_t pc;

  word_t mem [mem_words];
  word_t image [mem_words];
  word_t model_mem [mem_words];
  word_t rng = 32'd83;
  word_t exp_pc [$];                           // fetch address per executed instruction
  int    exp_cycles [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  int    exp_st_instr [$];                     // instruction index of each store
  int    store_idx = 0;
  int    freeze_st = 0;
  int    err_reset = 0;
  int    err_fetch = 0;
  int    err_freeze = 0;
  int    err_store = 0;
  int    err_count = 0;
  int    tests_failed = 0;
  bit    model_done = 1'b0;
  bit    timed_out = 1'b0;

  always #10 clk = ~clk;

  rv32i_multicycle_core rv32i_multicycle_core_inst (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_addr    (mem_addr),
    .mem_rd_data (mem_rd_data),
    .mem_wr_data (mem_wr_data),
    .mem_wr_en   (mem_wr_en),
    .pc          (pc)
  );

  always @(posedge clk) begin                  // one-cycle synchronous memory
    if (mem_wr_en === 1'b1) mem[mem_addr[9:2]] <= mem_wr_data;
    mem_rd_data <= mem[mem_addr[9:2]];
  end

  always @(negedge clk) begin                  // store order against the model
    if (rst === 1'b0 && mem_wr_en === 1'b1) begin
      if (store_idx >= exp_st_addr.size()) begin
        $display("store %0d to 0x%08h was not expected by the model", store_idx, mem_addr);
        err_store++;
      end else begin
        if (mem_addr !== exp_st_addr[store_idx]) begin
          $display("Error: mem_addr of store %0d expected 0x%08h actual 0x%08h",
                   store_idx, exp_st_addr[store_idx], mem_addr);
          err_store++;
        end
        if (mem_wr_data !== exp_st_data[store_idx]) begin
          $display("Error: mem_wr_data of store %0d expected 0x%08h actual 0x%08h",
                   store_idx, exp_st_data[store_idx], mem_wr_data);
          err_store++;
        end
      end
      store_idx++;
    end
  end

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // integer op by funct3, alt selects sub / sra
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t y;
    case (f3)
      3'd0: y = alt ? a - b : a + b;
      3'd1: y = a << b[4:0];
      3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: y = (a < b) ? 32'd1 : 32'd0;
      3'd4: y = a ^ b;
      3'd5: begin
        if (alt) y = $signed(a) >>> b[4:0];
        else y = a >> b[4:0];
      end
      3'd6: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  task automatic build_program();
    word_t       r;
    word_t       q;
    int          i;
    int          off;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    for (i = 0; i < mem_words; i++) begin
      image[i] = 32'h9e37_79b9 * (word_t'(i) + 32'd1);
    end
    for (i = 0; i < 15; i++) begin             // addi x1..x15, x0, random
      r = next_rand();
      image[i] = {r[31:20], 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
    end
    for (i = 15; i < prog_len; i++) begin
      r    = next_rand();
      q    = next_rand();
      rd   = 5'(1 + q[3:0] % 15);
      rs1  = 5'(1 + q[7:4] % 15);
      rs2  = 5'(1 + q[11:8] % 15);
      f3   = r[2:0];
      off  = 1 + int'(r[9:8]);                 // forward only, 1 to 4 words
      if (i + off > prog_len) off = prog_len - i;
      boff = 13'(off * 4);
      joff = 21'(off * 4);
      imm  = 12'h380 + {5'd0, r[8:4], 2'b00};  // data words 224 to 255
      case (r[31:24] % 13)
        0, 1, 2, 3: image[i] = {((f3 == 3'd0 || f3 == 3'd5) && r[3]) ? 7'h20 : 7'h00,
                                rs2, rs1, f3, rd, 7'b0110011};
        4, 5, 6, 7: begin
          if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {(f3 == 3'd5 && r[3]) ? 7'h20 : 7'h00, r[8:4]};   // shift amount
          end else begin
            imm = q[31:20];
          end
          image[i] = {imm, rs1, f3, rd, 7'b0010011};
        end
        8:  image[i] = {imm, 5'd0, 3'b010, rd, 7'b0000011};
        9:  image[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
        10: image[i] = {boff[12], boff[10:5], rs2, rs1, 2'b00, r[3], boff[4:1], boff[11],
                        7'b1100011};
        11: image[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        default: image[i] = {q[31:12], rd, 7'b0110111};             // lui, not in the core
      endcase
    end
    for (i = 0; i < 15; i++) begin             // dump x1..x15
      imm = 12'h380 + 12'(4 * i);
      image[prog_len + i] = {imm[11:5], 5'(i + 1), 5'd0, 3'b010, imm[4:0], 7'b0100011};
    end
    image[prog_len + 15] = {25'd0, 7'b1101111};   // jal x0, 0
  endtask

  task automatic run_model();
    word_t      xreg [32];
    word_t      pc_m;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      nxt;
    word_t      val;
    word_t      addr;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       wr;
    int         cyc;
    int         steps;
    int         j;
    for (j = 0; j < 32; j++) xreg[j] = '0;
    pc_m  = pc_start;
    steps = 0;
    while (!model_done && steps < timeout_cyc) begin
      ins   = model_mem[pc_m[9:2]];
      f3    = ins[14:12];
      f7    = ins[31:25];
      a     = xreg[ins[19:15]];
      b     = xreg[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt   = pc_m + 32'd4;
      cyc   = 3;                               // br, jal and unknown words
      wr    = 1'b0;
      val   = '0;
      case (ins[6:0])
        7'b0110011: begin
          if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
            val = alu_ref(f3, f7[5], a, b);
            wr  = 1'b1;
            cyc = 4;
          end
        end
        7'b0010011: begin
          if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
            val = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
            wr  = 1'b1;
            cyc = 4;
          end
        end
        7'b0000011: begin
          if (f3 == 3'b010) begin
            addr = a + imm_i;
            val  = model_mem[addr[9:2]];
            wr   = 1'b1;
            cyc  = 5;
          end
        end
        7'b0100011: begin
          if (f3 == 3'b010) begin
            addr = a + imm_s;
            model_mem[addr[9:2]] = b;
            exp_st_addr.push_back(addr);
            exp_st_data.push_back(b);
            exp_st_instr.push_back(exp_pc.size());
            cyc = 4;
          end
        end
        7'b1100011: begin
          if (f3[2:1] == 2'b00 && ((a == b) != f3[0])) nxt = pc_m + imm_b;
        end
        7'b1101111: begin
          val = pc_m + 32'd4;
          wr  = 1'b1;
          nxt = pc_m + imm_j;
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) xreg[ins[11:7]] = val;
      exp_pc.push_back(pc_m);
      exp_cycles.push_back(cyc);
      if (nxt == pc_m) model_done = 1'b1;      // parked on the self-loop
      pc_m = nxt;
      steps++;
    end
  endtask

  // entered at the fetch negedge, returns at the next fetch negedge
  task automatic step_instruction(input int k, input bit freeze);
    int i;
    if (mem_addr !== exp_pc[k]) begin
      $display("Error: mem_addr at fetch %0d expected 0x%08h actual 0x%08h",
               k, exp_pc[k], mem_addr);
      err_fetch++;
    end
    for (i = 1; i < exp_cycles[k]; i++) begin
      @(posedge clk);
    end
    if (freeze) begin                          // held in the memory step of a store
      ena <= 1'b0;
      for (i = 0; i < freeze_len; i++) begin
        @(negedge clk);
        if (pc !== exp_pc[k + 1]) begin
          $display("Error: pc while frozen expected 0x%08h actual 0x%08h",
                   exp_pc[k + 1], pc);
          err_freeze++;
        end
        if (mem_addr !== exp_st_addr[freeze_st]) begin
          $display("Error: mem_addr while frozen expected 0x%08h actual 0x%08h",
                   exp_st_addr[freeze_st], mem_addr);
          err_freeze++;
        end
        if (mem_wr_en !== 1'b0) begin
          $display("Error: mem_wr_en while frozen expected 0x0 actual 0x%0h", mem_wr_en);
          err_freeze++;
        end
        @(posedge clk);
      end
      ena <= 1'b1;
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_for_pc(input word_t target);
    int n;
    n = 0;
    while (pc !== target && n < timeout_cyc) begin
      @(negedge clk);
      n++;
    end
    if (pc !== target) begin
      $display("timeout: pc did not reach 0x%08h within %0d cycles", target, timeout_cyc);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errs);
      tests_failed++;
    end
  endtask

  initial begin
    int    k;
    int    freeze_k;
    int    pick;
    word_t loop_pc;
    rst         = 1'b1;
    ena         = 1'b1;
    mem_rd_data = '0;
    build_program();
    mem       = image;
    model_mem = image;
    run_model();
    if (!model_done) begin
      $display("model never reached the self-loop, the program is unusable");
      err_count++;
    end
    loop_pc  = exp_pc[exp_pc.size() - 1];
    freeze_k = -1;
    if (exp_st_instr.size() > 0) begin         // first store at or after a random point
      pick      = 40 + int'(next_rand() % 60);
      freeze_st = 0;
      while (freeze_st < exp_st_instr.size() - 1 && exp_st_instr[freeze_st] < pick) begin
        freeze_st++;
      end
      freeze_k = exp_st_instr[freeze_st];
    end

    for (k = 0; k < 16; k++) begin
      @(posedge clk);
      @(negedge clk);
      if (mem_wr_en !== 1'b0) begin
        $display("Error: mem_wr_en in reset expected 0x0 actual 0x%0h", mem_wr_en);
        err_reset++;
      end
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (pc !== pc_start) begin
      $display("Error: pc after reset expected 0x%08h actual 0x%08h", pc_start, pc);
      err_reset++;
    end
    report_test("reset", err_reset);

    for (k = 0; k < exp_pc.size(); k++) begin
      step_instruction(k, k == freeze_k);
    end
    if (mem_addr !== loop_pc) begin
      $display("Error: mem_addr at self-loop expected 0x%08h actual 0x%08h", loop_pc, mem_addr);
      err_fetch++;
    end
    report_test("fetch order", err_fetch);
    report_test("freeze", err_freeze);
    wait_for_pc(loop_pc);
    report_test("store order", err_store);
    if (store_idx != exp_st_addr.size()) begin
      $display("core made %0d stores, model expects %0d", store_idx, exp_st_addr.size());
      err_count++;
    end
    report_test("store count", err_count + int'(timed_out));
    $display("5 tests, %0d failing, %0d errors in all", tests_failed,
             err_reset + err_fetch + err_freeze + err_store + err_count);
    if (tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rv32i_pkg.sv
rv32i_alu.sv
register_file.sv
immediate_extender.sv
instruction_decoder.sv
core_controller.sv
rv32i_multicycle_core.sv
tb_rv32i_core.sv

// File: Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - rv32i_pkg.sv
  - rv32i_alu.sv
  - register_file.sv
  - immediate_extender.sv
  - instruction_decoder.sv
  - core_controller.sv
  - rv32i_multicycle_core.sv
  - target: simulation
    files:
      - tb_rv32i_core.sv
